// ==== src.f ====
legShiftPkg.sv
shiftControl.sv
shiftDecoder.sv
barrelShifter.sv
shiftRequestPort.sv
shifterUnit.sv
shifterChk.sv
shifterTb.sv

// ==== shifterTb.sv ====
// Operand shifter testbench
`default_nettype none

module shifterTb;

  typedef logic [legShiftPkg::wordBits-1:0] wordT;

  localparam int numReq      = 396;  // Sum over all phases
  localparam int resetCycles = 4;

  logic                   clk;
  logic                   reset;
  logic                   req;
  logic                   ack;
  legShiftPkg::shiftReqT  reqData;
  legShiftPkg::shiftRespT respData;

  legShiftPkg::shiftReqT  pending;  // Request in flight
  logic                   busy;     // Handshake open
  logic                   bpOn;     // Random hold before req drops
  logic [31:0]            lfsr = 32'h354a_880b;
  int                     checked;
  int                     operandErrors;
  int                     carryErrors;
  int                     protocolErrors;

  shifterUnit u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ack      (ack),
    .reqData  (reqData),
    .respData (respData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic wordT rotateRight(input wordT v, input int m);
    return (v >> m) | (v << (legShiftPkg::wordBits - m));  // m of 0 gives v
  endfunction

  // ARM shift by a plain amount 0 to 255
  function automatic legShiftPkg::shiftRespT shiftWord(input wordT v,
      input legShiftPkg::shiftTypeT t, input int amt, input logic c);
    legShiftPkg::shiftRespT res;
    int                     m;
    res.operand  = v;
    res.carryOut = c;  // Amount zero keeps C
    m = amt % legShiftPkg::wordBits;
    if (amt != 0) begin
      case (t)
        legShiftPkg::shLsl: begin
          res.operand  = (amt < 32) ? v << amt : '0;
          res.carryOut = (amt < 32) ? v[32 - amt] : ((amt == 32) ? v[0] : 1'b0);
        end
        legShiftPkg::shLsr: begin
          res.operand  = (amt < 32) ? v >> amt : '0;
          res.carryOut = (amt < 32) ? v[amt - 1] : ((amt == 32) ? v[31] : 1'b0);
        end
        legShiftPkg::shAsr: begin
          res.operand  = (amt < 32) ? wordT'($signed(v) >>> amt) : {32{v[31]}};
          res.carryOut = (amt < 32) ? v[amt - 1] : v[31];
        end
        default: begin
          res.operand  = rotateRight(v, m);
          res.carryOut = (m == 0) ? v[31] : v[m - 1];  // Multiples of 32 give bit 31
        end
      endcase
    end
    return res;
  endfunction

  // Expected response per class
  function automatic legShiftPkg::shiftRespT refShift(input legShiftPkg::shiftReqT r);
    legShiftPkg::shiftRespT res;
    wordT                   imm;
    res.operand  = r.rmValue;
    res.carryOut = r.prevC;
    case (r.opClass)
      legShiftPkg::regImm: begin
        if (r.immShamt == 0 && r.shType == legShiftPkg::shRor) begin
          res.operand  = {r.prevC, r.rmValue[31:1]};  // RRX
          res.carryOut = r.rmValue[0];
        end else if (r.immShamt == 0 && r.shType != legShiftPkg::shLsl) begin
          res = shiftWord(r.rmValue, r.shType, 32, r.prevC);  // LSR/ASR #0 is #32
        end else begin
          res = shiftWord(r.rmValue, r.shType, int'(r.immShamt), r.prevC);
        end
      end
      legShiftPkg::regReg: res = shiftWord(r.rmValue, r.shType, int'(r.regShamt), r.prevC);
      legShiftPkg::immRot: begin
        imm = {24'h0, r.imm8};
        res.operand = rotateRight(imm, 2 * int'(r.rot4));
        if (r.rot4 != 0) begin
          res.carryOut = res.operand[31];
        end
      end
      default: ;  // memReg passes through
    endcase
    return res;
  endfunction

  task automatic checkOperand(input string sig, input wordT got, input wordT exp);
    if (got !== exp) begin
      operandErrors++;
      $display("[ERROR] t=%0t %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic checkCarry(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      carryErrors++;
      $display("[ERROR] t=%0t %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  // Every field random
  task automatic randomReq(output legShiftPkg::shiftReqT r);
    logic [31:0] bits;
    bits = randBits(2);
    r.opClass = legShiftPkg::opClassT'(bits[1:0]);
    bits = randBits(2);
    r.shType = legShiftPkg::shiftTypeT'(bits[1:0]);
    bits = randBits(5);
    r.immShamt = bits[4:0];
    bits = randBits(8);
    r.regShamt = bits[7:0];
    bits = randBits(8);
    r.imm8 = bits[7:0];
    bits = randBits(4);
    r.rot4 = bits[3:0];
    bits = randBits(1);
    r.prevC = bits[0];
    r.rmValue = randBits(32);
  endtask

  task automatic sendReq(input legShiftPkg::shiftReqT r);
    wait (!busy);
    @(posedge clk);
    reqData <= r;
    req     <= 1'b1;
    pending = r;
    busy    = 1'b1;
  endtask

  // Stimulus
  initial begin
    legShiftPkg::shiftReqT r;
    logic [7:0]            specials [0:10];
    specials = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd64, 8'd96, 8'd128, 8'd160, 8'd224, 8'd255};
    reset          = 1'b1;
    req            = 1'b0;
    reqData        = '0;
    busy           = 1'b0;
    bpOn           = 1'b0;
    checked        = 0;
    operandErrors  = 0;
    carryErrors    = 0;
    protocolErrors = 0;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    // Reset values
    if (ack !== 1'b0) begin
      protocolErrors++;
      $display("ack was not low after reset at t=%0t", $time);
    end
    checkOperand("respData.operand", respData.operand, '0);
    checkCarry("respData.carryOut", respData.carryOut, 1'b0);
    for (int t = 0; t < 4; t++) begin  // Immediate amounts 1 to 31
      for (int a = 1; a < 32; a++) begin
        randomReq(r);
        r.opClass  = legShiftPkg::regImm;
        r.shType   = legShiftPkg::shiftTypeT'(t[1:0]);
        r.immShamt = a[4:0];
        sendReq(r);
      end
    end
    for (int t = 0; t < 4; t++) begin
      repeat (4) begin  // Zero amount, RRX for ROR
        randomReq(r);
        r.opClass  = legShiftPkg::regImm;
        r.shType   = legShiftPkg::shiftTypeT'(t[1:0]);
        r.immShamt = '0;
        sendReq(r);
      end
    end
    for (int t = 0; t < 4; t++) begin
      for (int i = 0; i < 11; i++) begin  // Corner Rs bytes
        randomReq(r);
        r.opClass  = legShiftPkg::regReg;
        r.shType   = legShiftPkg::shiftTypeT'(t[1:0]);
        r.regShamt = specials[i];
        sendReq(r);
      end
      repeat (30) begin
        randomReq(r);
        r.opClass = legShiftPkg::regReg;
        r.shType  = legShiftPkg::shiftTypeT'(t[1:0]);
        sendReq(r);
      end
    end
    repeat (20) begin
      randomReq(r);
      r.opClass = legShiftPkg::memReg;  // Shift fields stay random
      sendReq(r);
    end
    for (int k = 0; k < 16; k++) begin
      repeat (2) begin
        randomReq(r);
        r.opClass = legShiftPkg::immRot;
        r.rot4    = k[3:0];
        sendReq(r);
      end
    end
    bpOn = 1'b1;  // Requester stalls before dropping req
    repeat (40) begin
      randomReq(r);
      sendReq(r);
    end
    wait (!busy);
    @(posedge clk);
    if (checked != numReq) begin
      protocolErrors++;
      $display("Only %0d of %0d responses were checked", checked, numReq);
    end
    protocolErrors += u_dut.u_port.u_chk.failCount;  // Bound assertion failures
    $display("Summary: %0d checked, %0d operand errors, %0d carry errors, %0d handshake errors",
             checked, operandErrors, carryErrors, protocolErrors);
    if (operandErrors + carryErrors + protocolErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Compare and close the handshake
  initial begin
    legShiftPkg::shiftRespT exp;
    legShiftPkg::shiftRespT first;
    logic [31:0]            hold;
    forever begin
      wait (busy);
      @(posedge clk);
      while (!ack) @(posedge clk);
      exp = refShift(pending);
      checkOperand("respData.operand", respData.operand, exp.operand);
      checkCarry("respData.carryOut", respData.carryOut, exp.carryOut);
      first = respData;
      hold  = bpOn ? randBits(2) : '0;
      repeat (hold) begin
        @(posedge clk);
        if (!ack) begin
          protocolErrors++;
          $display("ack dropped at t=%0t while req was still high", $time);
        end
        checkOperand("respData.operand", respData.operand, first.operand);  // Held value
        checkCarry("respData.carryOut", respData.carryOut, first.carryOut);
      end
      req <= 1'b0;
      do @(posedge clk); while (ack);  // Port back in idle
      checked++;
      busy = 1'b0;
    end
  end

  // Watchdog, ten cycles per request
  initial begin
    repeat (numReq * 10 + resetCycles) @(posedge clk);
    $display("Timeout with %0d of %0d responses checked", checked, numReq);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== shifterChk.sv ====
// Request port handshake checks
`default_nettype none

module shifterChk (
  input logic                   clk,
  input logic                   reset,
  input logic                   req,
  input logic                   ack,
  input legShiftPkg::shiftRespT respData
);

  int failCount = 0;  // Failed assertions so far

  // Req first seen in idle, ack follows two edges on
  property ackLatency;
    @(posedge clk) disable iff (reset)
      $rose(req) |-> !ack ##1 !ack ##1 ack;
  endproperty

  // Response frozen for the whole ack phase
  property respStable;
    @(posedge clk) disable iff (reset)
      (ack && $past(ack)) |-> $stable(respData);
  endproperty

  property ackNeedsReq;
    @(posedge clk) disable iff (reset)
      $rose(ack) |-> req;  // No ack without a request
  endproperty

  aLatency: assert property (ackLatency)
    else begin
      failCount++;
      $error("ack did not rise two edges after req was first seen");
    end
  aStable: assert property (respStable)
    else begin
      failCount++;
      $error("respData changed while ack was high");
    end
  aNoReq: assert property (ackNeedsReq)
    else begin
      failCount++;
      $error("ack rose while req was low");
    end

endmodule

bind shiftRequestPort shifterChk u_chk (
  .clk      (clk),
  .reset    (reset),
  .req      (req),
  .ack      (ack),
  .respData (respData)
);

`default_nettype wire

// ==== shifterUnit.sv ====
// Operand 2 shifter top
`default_nettype none

module shifterUnit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req,
  output logic                    ack,
  input  legShiftPkg::shiftReqT   reqData,
  output legShiftPkg::shiftRespT  respData
);

  legShiftPkg::shiftReqT                  held;
  legShiftPkg::shiftCtlT                  ctl;
  logic [legShiftPkg::wordBits-1:0]      srcA;
  logic [legShiftPkg::wordBits-1:0]      result;
  logic [legShiftPkg::shamtBits-1:0]     rotAmount;
  logic [legShiftPkg::wordBits-1:0]      keepMask;
  logic                                   rot0;
  logic                                   rot31;
  logic                                   carryOut;

  // Handshake and registers
  shiftRequestPort u_port (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .ack      (ack),
    .reqData  (reqData),
    .held     (held),
    .srcA     (srcA),
    .result   (result),
    .carryOut (carryOut),
    .respData (respData)
  );

  // Amount, direction and carry
  shiftControl u_ctl (
    .held     (held),
    .srcA     (srcA),
    .rot0     (rot0),
    .rot31    (rot31),
    .ctl      (ctl),
    .carryOut (carryOut)
  );

  shiftDecoder u_dec (
    .ctl       (ctl),
    .rotAmount (rotAmount),
    .keepMask  (keepMask)
  );

  // Word-wide datapath
  barrelShifter #(
    .dataBits (legShiftPkg::wordBits)
  ) u_bsh (
    .srcA      (srcA),
    .ctl       (ctl),
    .rotAmount (rotAmount),
    .keepMask  (keepMask),
    .result    (result),
    .rot0      (rot0),
    .rot31     (rot31)
  );

endmodule

`default_nettype wire

// ==== shiftRequestPort.sv ====
// Four-phase request port
`default_nettype none

module shiftRequestPort (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               req,
  output logic                               ack,
  input  legShiftPkg::shiftReqT              reqData,
  output legShiftPkg::shiftReqT              held,      // Captured request
  output logic [legShiftPkg::wordBits-1:0]  srcA,
  input  logic [legShiftPkg::wordBits-1:0]  result,
  input  logic                               carryOut,
  output legShiftPkg::shiftRespT             respData
);

  typedef enum logic [1:0] {
    stIdle    = 2'b00,  // Waiting for req
    stCompute = 2'b01,  // Shifter settles on held
    stAck     = 2'b10   // Holding ack until req drops
  } portStateT;

  portStateT state;
  portStateT stateNext;
  logic      capture;
  logic      load;

  assign capture = (state == stIdle) && req;
  assign load    = state == stCompute;

  // Next state
  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (req) begin
          stateNext = stCompute;
        end
      end
      stCompute: stateNext = stAck;  // Response registered this edge
      stAck: begin
        if (!req) begin
          stateNext = stIdle;  // Ack falls on the edge that sees req low
        end
      end
      default: stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (capture) begin
      held <= reqData;
    end
  end

  // Response, stable for the whole ack phase
  always_ff @(posedge clk) begin
    if (reset) begin
      respData <= '0;
    end else if (load) begin
      respData.operand  <= result;
      respData.carryOut <= carryOut;
    end
  end

  assign ack = state == stAck;

  // Shifter input word
  always_comb begin
    if (held.opClass == legShiftPkg::immRot) begin
      srcA = {{(legShiftPkg::wordBits - legShiftPkg::imm8Bits){1'b0}}, held.imm8};
    end else begin
      srcA = held.rmValue;  // Register and memory offset classes
    end
  end

endmodule

`default_nettype wire

// ==== barrelShifter.sv ====
// Barrel rotator with mask and fill
`default_nettype none

module barrelShifter #(
  parameter int dataBits = 32
) (
  input  logic [dataBits-1:0]          srcA,
  input  legShiftPkg::shiftCtlT        ctl,
  input  logic [$clog2(dataBits)-1:0]  rotAmount,
  input  logic [dataBits-1:0]          keepMask,
  output logic [dataBits-1:0]          result,
  output logic                         rot0,
  output logic                         rot31
);

  localparam int stages = $clog2(dataBits);  // Five for a 32-bit word

  logic [dataBits-1:0] stage [0:stages];
  logic [dataBits-1:0] rotated;
  logic                fill;
  logic                rrxCase;

  assign stage[0] = srcA;

  // Rotate right by 1, 2, 4, 8, 16
  for (genvar k = 0; k < stages; k++) begin : gRot
    localparam int step = 1 << k;
    assign stage[k+1] = rotAmount[k] ?
                        {stage[k][step-1:0], stage[k][dataBits-1:step]} :
                        stage[k];
  end

  assign rotated = stage[stages];
  assign rot0    = rotated[0];
  assign rot31   = rotated[dataBits-1];

  // Sign bit for ASR, zero otherwise
  assign fill = ctl.arith & srcA[dataBits-1];

  // Only a rotate by one can be RRX
  assign rrxCase = ctl.rotateOnly && (rotAmount == 1);

  always_comb begin
    for (int i = 0; i < dataBits; i++) begin
      // Long shifts blank every position
      result[i] = (keepMask[i] && !ctl.longShift) ? rotated[i] : fill;
    end
    if (rrxCase) begin
      result[dataBits-1] = ctl.rrxIn;  // C in on top for RRX
    end
  end

endmodule

`default_nettype wire

// ==== shiftDecoder.sv ====
// Shift amount decoder
`default_nettype none

module shiftDecoder (
  input  legShiftPkg::shiftCtlT                ctl,
  output logic [legShiftPkg::shamtBits-1:0]   rotAmount,
  output logic [legShiftPkg::wordBits-1:0]    keepMask
);

  localparam logic [legShiftPkg::wordBits-1:0] allOnes = '1;

  // Left by n is right rotate by 32-n, mod 32
  always_comb begin
    rotAmount = ctl.shamt;
    if (ctl.left) begin
      rotAmount = ~ctl.shamt + 1'b1;  // Two's complement negate
    end
  end

  // Thermometer of bit positions that survive
  always_comb begin
    if (ctl.rotateOnly) begin
      keepMask = allOnes;              // Rotates lose nothing
    end else if (ctl.left) begin
      keepMask = allOnes << ctl.shamt;  // High bits stay
    end else begin
      keepMask = allOnes >> ctl.shamt;  // Low bits stay
    end
  end

endmodule

`default_nettype wire

// ==== shiftControl.sv ====
// Shifter control and carry select
`default_nettype none

module shiftControl (
  input  legShiftPkg::shiftReqT              held,
  input  logic [legShiftPkg::wordBits-1:0]  srcA,
  input  logic                               rot0,   // Rotated bit 0
  input  logic                               rot31,  // Rotated top bit
  output legShiftPkg::shiftCtlT              ctl,
  output logic                               carryOut
);

  logic       isShift;   // regImm or regReg
  logic       isRegAmt;  // Amount comes from Rs
  logic       rrx;
  logic [6:0] effShift;  // Effective amount, up to 127
  logic       shift0;
  logic       shift32;
  logic       shift33;
  logic       lsb;
  logic       msb;

  assign isRegAmt = held.opClass == legShiftPkg::regReg;
  assign isShift  = isRegAmt || (held.opClass == legShiftPkg::regImm);

  // ROR #0 in the immediate form encodes RRX
  assign rrx = (held.opClass == legShiftPkg::regImm) &&
               (held.shType == legShiftPkg::shRor) &&
               (held.immShamt == '0);

  assign lsb = srcA[0];
  assign msb = srcA[legShiftPkg::wordBits-1];

  // Effective amount per class
  always_comb begin
    case (held.opClass)
      legShiftPkg::regImm: begin
        if (rrx) begin
          effShift = 7'd1;  // RRX runs as ROR #1 with C fill
        end else if ((held.immShamt == '0) && (held.shType != legShiftPkg::shLsl)) begin
          effShift = 7'd32;  // LSR/ASR #0 means #32
        end else begin
          effShift = {2'b00, held.immShamt};
        end
      end
      legShiftPkg::regReg: begin
        // Bits 7:6 fold into one saturating flag
        effShift = {|held.regShamt[7:6], held.regShamt[5:0]};
      end
      legShiftPkg::immRot: effShift = {2'b00, held.rot4, 1'b0};  // Twice rot4
      default:             effShift = 7'd0;                      // memReg passes through
    endcase
  end

  assign shift0  = effShift == 7'd0;
  assign shift32 = effShift == 7'd32;
  assign shift33 = effShift > 7'd32;

  // Barrel shifter controls
  always_comb begin
    ctl.shamt      = effShift[4:0];
    ctl.left       = isShift && (held.shType == legShiftPkg::shLsl);
    ctl.arith      = isShift && (held.shType == legShiftPkg::shAsr);
    ctl.rotateOnly = !isShift || (held.shType == legShiftPkg::shRor);
    // ROR by 32 and more just wraps, so no blanking there
    ctl.longShift  = isShift && (held.shType != legShiftPkg::shRor) && (|effShift[6:5]);
    ctl.rrxIn      = rrx ? held.prevC : lsb;  // Plain ROR #1 keeps bit 0 on top
  end

  // Carry out select
  always_comb begin
    carryOut = held.prevC;  // memReg, immRot with rot4 zero
    if (isShift) begin
      if (shift0) begin
        carryOut = held.prevC;  // LSL #0 or Rs byte zero
      end else if (shift33) begin
        case (held.shType)
          legShiftPkg::shLsl: carryOut = 1'b0;
          legShiftPkg::shLsr: carryOut = 1'b0;
          legShiftPkg::shAsr: carryOut = msb;
          default:            carryOut = rot31;  // ROR reduced mod 32
        endcase
      end else if (shift32) begin
        // LSL #32 only reachable from regReg
        carryOut = (held.shType == legShiftPkg::shLsl) ? lsb : msb;
      end else begin
        // 1 to 31, last bit shifted out; RRX lands here with rot31 = bit 0
        carryOut = (held.shType == legShiftPkg::shLsl) ? rot0 : rot31;
      end
    end else if ((held.opClass == legShiftPkg::immRot) && (held.rot4 != '0)) begin
      carryOut = rot31;  // Top bit of rotated immediate
    end
  end

endmodule

`default_nettype wire

// ==== legShiftPkg.sv ====
// Operand shifter shared types
`default_nettype none

package legShiftPkg;

  // Word and field sizes
  localparam int wordBits     = 32;
  localparam int shamtBits    = 5;   // Rotate amount within one word
  localparam int regShamtBits = 8;   // Low byte of Rs
  localparam int imm8Bits     = 8;
  localparam int rot4Bits     = 4;

  // Operand 2 source class
  typedef enum logic [1:0] {
    regImm = 2'b00,  // Rm shifted by immediate, RRX included
    regReg = 2'b01,  // Rm shifted by Rs[7:0]
    memReg = 2'b10,  // Load/store register offset, no shift
    immRot = 2'b11   // imm8 rotated right by 2*rot4
  } opClassT;

  // Shift type field, instruction encoding order
  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftTypeT;

  // One shift request
  typedef struct packed {
    opClassT                 opClass;
    shiftTypeT               shType;
    logic [shamtBits-1:0]    immShamt;  // Instruction shift field
    logic [regShamtBits-1:0] regShamt;  // Rs bottom byte
    logic [imm8Bits-1:0]     imm8;
    logic [rot4Bits-1:0]     rot4;
    logic                    prevC;     // Current C flag
    logic [wordBits-1:0]     rmValue;
  } shiftReqT;

  // Shifter answer
  typedef struct packed {
    logic [wordBits-1:0] operand;
    logic                carryOut;
  } shiftRespT;

  // Barrel shifter controls
  typedef struct packed {
    logic [shamtBits-1:0] shamt;       // Effective amount mod 32
    logic                 left;        // LSL
    logic                 arith;       // ASR sign fill
    logic                 rotateOnly;  // No masking, pure rotate
    logic                 longShift;   // 32 or more, every bit is fill
    logic                 rrxIn;       // Top bit for a rotate by one
  } shiftCtlT;

endpackage

`default_nettype wire
